// ==== hdl/rp_params.svh ====
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

// channel counts
`define RP_CHN          2
`define RP_PDM_CHN      4

// sample widths
`define RP_ADC_DW       16
`define RP_DAC_DW       14

// PDM level width and full-scale range
`define RP_PDM_DW       8
`define RP_PDM_RNG      255

// DAC code at mid-scale, loaded on reset
`define RP_DAC_RST_VAL  14'h1FFF

// register map
`define RP_REG_AW       3
`define RP_ADDR_LOOP    0
// PDM channel n at RP_ADDR_PDM0 + n
`define RP_ADDR_PDM0    1

`endif

// ==== hdl/rp_pkg.sv ====
`include "rp_params.svh"

package rp_pkg;

  // raw ADC word, offset binary with negative slope
  typedef logic        [`RP_ADC_DW-1:0] adc_raw_t;

  // oscilloscope sample, two's complement
  typedef logic signed [`RP_ADC_DW-1:0] osc_dat_t;

  // generator sample, two's complement
  typedef logic signed [`RP_DAC_DW-1:0] gen_dat_t;

  // raw DAC code, offset binary with negative slope
  typedef logic        [`RP_DAC_DW-1:0] dac_raw_t;

  // PDM density level
  typedef logic        [`RP_PDM_DW-1:0] pdm_lvl_t;

  // one loop enable per channel
  typedef logic        [`RP_CHN-1:0]    loop_mask_t;

  // register port
  typedef logic        [`RP_REG_AW-1:0] reg_addr_t;
  typedef logic        [`RP_PDM_DW-1:0] reg_data_t;

endpackage

// ==== hdl/adc_frontend.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module adc_frontend (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // raw words from the ADC pins
  input  rp_pkg::adc_raw_t [`RP_CHN-1:0] adc_dat_i,
  // converted samples, valid one edge after capture
  output rp_pkg::osc_dat_t [`RP_CHN-1:0] adc_tc_o
);

  // input capture registers, one per channel
  rp_pkg::adc_raw_t [`RP_CHN-1:0] adc_raw;

  // capture at every edge
  // lowest 2 bits only meaningful on a 16-bit part
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  // negative slope offset binary to two's complement
  // sign bit passes, the rest is inverted
  always_comb begin
    for (int c = 0; c < `RP_CHN; c++) begin
      adc_tc_o[c] = {adc_raw[c][`RP_ADC_DW-1], ~adc_raw[c][`RP_ADC_DW-2:0]};
    end
  end

endmodule

// ==== hdl/dac_backend.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module dac_backend (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // signed generator samples
  input  rp_pkg::gen_dat_t [`RP_CHN-1:0] dac_smp_i,
  // one update strobe per channel
  input  logic             [`RP_CHN-1:0] dac_vld_i,
  // codes toward the DAC pins
  output rp_pkg::dac_raw_t [`RP_CHN-1:0] dac_dat_o
);

  // converted codes, before the output register
  rp_pkg::dac_raw_t [`RP_CHN-1:0] dac_cnv;

  // signed to offset binary, also flips the slope
  always_comb begin
    for (int c = 0; c < `RP_CHN; c++) begin
      dac_cnv[c] = {dac_smp_i[c][`RP_DAC_DW-1], ~dac_smp_i[c][`RP_DAC_DW-2:0]};
    end
  end

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  // mid-scale out of reset
  // new code only on a valid sample, hold otherwise
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        dac_dat_o[c] <= `RP_DAC_RST_VAL;
      end
    end else begin
      for (int c = 0; c < `RP_CHN; c++) begin
        if (dac_vld_i[c]) begin
          dac_dat_o[c] <= dac_cnv[c];
        end
      end
    end
  end

endmodule

// ==== hdl/loop_router.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module loop_router (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // per channel loop enable
  input  rp_pkg::loop_mask_t             loop_i,
  // converted ADC samples
  input  rp_pkg::osc_dat_t [`RP_CHN-1:0] adc_tc_i,
  // generator samples and strobes
  input  rp_pkg::gen_dat_t [`RP_CHN-1:0] gen_dat_i,
  input  logic             [`RP_CHN-1:0] gen_vld_i,
  // toward the DAC back end
  output rp_pkg::gen_dat_t [`RP_CHN-1:0] dac_smp_o,
  output logic             [`RP_CHN-1:0] dac_vld_o,
  // toward the oscilloscope
  output rp_pkg::osc_dat_t [`RP_CHN-1:0] osc_dat_o,
  output logic             [`RP_CHN-1:0] osc_vld_o
);

  // zero LSBs appended when a generator sample is looped back
  localparam int unsigned PAD_W = `RP_ADC_DW - `RP_DAC_DW;

  // ADC stream is free running
  // first converted word after reset comes from the cleared capture register
  logic adc_fill;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_fill <= 1'b0;
    end else begin
      adc_fill <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // generator demux
  //////////////////////////////////////////////////

  // data goes through untouched
  assign dac_smp_o = gen_dat_i;
  // strobe withheld from the DAC while looped, so it holds
  assign dac_vld_o = gen_vld_i & ~loop_i;

  //////////////////////////////////////////////////
  // oscilloscope mux
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      osc_dat_o <= '0;
      osc_vld_o <= '0;
    end else begin
      for (int c = 0; c < `RP_CHN; c++) begin
        if (loop_i[c]) begin
          // 14 bit generator scaled up to 16 bit scope range
          osc_dat_o[c] <= {gen_dat_i[c], {PAD_W{1'b0}}};
          osc_vld_o[c] <= gen_vld_i[c];
        end else begin
          // ADC sample, always valid once the pipe has filled
          osc_dat_o[c] <= adc_tc_i[c];
          osc_vld_o[c] <= adc_fill;
        end
      end
    end
  end

endmodule

// ==== hdl/pdm_modulator.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module pdm_modulator (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // density level per output
  input  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl_i,
  // one-bit density outputs
  output logic             [`RP_PDM_CHN-1:0] pdm_o
);

  // one extra bit, acc + level stays below twice the range
  localparam int unsigned ACC_W = `RP_PDM_DW + 1;
  localparam logic [ACC_W-1:0] RNG = ACC_W'(`RP_PDM_RNG);

  // residue carried between cycles, always below RNG
  logic [ACC_W-1:0] acc [`RP_PDM_CHN];
  // residue plus current level
  logic [ACC_W-1:0] sum [`RP_PDM_CHN];

  always_comb begin
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      sum[n] = acc[n] + ACC_W'(pdm_lvl_i[n]);
    end
  end

  // overflow past the range emits a one and drops the range
  // ones per RNG cycles then equal the level
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        acc[n] <= '0;
      end
      pdm_o <= '0;
    end else begin
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        if (sum[n] >= RNG) begin
          acc[n]   <= sum[n] - RNG;
          pdm_o[n] <= 1'b1;
        end else begin
          acc[n]   <= sum[n];
          pdm_o[n] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/analog_regs.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module analog_regs (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // access strobes
  input  logic                               reg_we_i,
  input  logic                               reg_re_i,
  input  rp_pkg::reg_addr_t                  reg_addr_i,
  input  rp_pkg::reg_data_t                  reg_wdata_i,
  // read return, one cycle after the strobe
  output rp_pkg::reg_data_t                  reg_rdata_o,
  output logic                               reg_rvalid_o,
  // configuration toward the data path
  output rp_pkg::loop_mask_t                 loop_o,
  output rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl_o
);

  // address hits
  logic                   hit_loop;
  logic [`RP_PDM_CHN-1:0] hit_pdm;
  // read data before the return register
  rp_pkg::reg_data_t      rd_data;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign hit_loop = (reg_addr_i == rp_pkg::reg_addr_t'(`RP_ADDR_LOOP));

  // PDM channels sit on consecutive addresses
  always_comb begin
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      hit_pdm[n] = (reg_addr_i == rp_pkg::reg_addr_t'(`RP_ADDR_PDM0 + n));
    end
  end

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  // unmapped addresses hit nothing, write is dropped
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_o    <= '0;
      pdm_lvl_o <= '0;
    end else if (reg_we_i) begin
      if (hit_loop) begin
        loop_o <= reg_wdata_i[`RP_CHN-1:0];
      end
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        if (hit_pdm[n]) begin
          pdm_lvl_o[n] <= reg_wdata_i;
        end
      end
    end
  end

  // read mux, zero for unmapped
  // loop mask zero extended
  always_comb begin
    rd_data = '0;
    if (hit_loop) begin
      rd_data[`RP_CHN-1:0] = loop_o;
    end
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      if (hit_pdm[n]) begin
        rd_data = pdm_lvl_o[n];
      end
    end
  end

  // read return register and single cycle valid
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      reg_rdata_o  <= '0;
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_re_i;
      if (reg_re_i) begin
        reg_rdata_o <= rd_data;
      end
    end
  end

endmodule

// ==== hdl/analog_top.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module analog_top (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // ADC pins
  input  rp_pkg::adc_raw_t [`RP_CHN-1:0]     adc_dat_i,
  // generator stream
  input  rp_pkg::gen_dat_t [`RP_CHN-1:0]     gen_dat_i,
  input  logic             [`RP_CHN-1:0]     gen_vld_i,
  // register port
  input  logic                               reg_we_i,
  input  logic                               reg_re_i,
  input  rp_pkg::reg_addr_t                  reg_addr_i,
  input  rp_pkg::reg_data_t                  reg_wdata_i,
  output rp_pkg::reg_data_t                  reg_rdata_o,
  output logic                               reg_rvalid_o,
  // oscilloscope stream
  output rp_pkg::osc_dat_t [`RP_CHN-1:0]     osc_dat_o,
  output logic             [`RP_CHN-1:0]     osc_vld_o,
  // DAC codes, one parallel port per channel
  output rp_pkg::dac_raw_t [`RP_CHN-1:0]     dac_dat_o,
  // PDM outputs
  output logic             [`RP_PDM_CHN-1:0] pdm_o
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  // ADC front end to router
  rp_pkg::osc_dat_t [`RP_CHN-1:0]     adc_tc;
  // router to DAC back end
  rp_pkg::gen_dat_t [`RP_CHN-1:0]     dac_smp;
  logic             [`RP_CHN-1:0]     dac_vld;
  // configuration
  rp_pkg::loop_mask_t                 loop;
  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl;

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_tc_o  (adc_tc)
  );

  // generator to DAC or back into the scope
  loop_router u_loop_router (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .loop_i    (loop),
    .adc_tc_i  (adc_tc),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .dac_smp_o (dac_smp),
    .dac_vld_o (dac_vld),
    .osc_dat_o (osc_dat_o),
    .osc_vld_o (osc_vld_o)
  );

  dac_backend u_dac_backend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_smp_i (dac_smp),
    .dac_vld_i (dac_vld),
    .dac_dat_o (dac_dat_o)
  );

  //////////////////////////////////////////////////
  // configuration and slow outputs
  //////////////////////////////////////////////////

  analog_regs u_analog_regs (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .reg_we_i     (reg_we_i),
    .reg_re_i     (reg_re_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .loop_o       (loop),
    .pdm_lvl_o    (pdm_lvl)
  );

  pdm_modulator u_pdm_modulator (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_lvl_i (pdm_lvl),
    .pdm_o     (pdm_o)
  );

endmodule

// ==== tests/analog_checker.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module analog_checker (
  input logic                           adc_clk,
  input logic                           top_rst,
  // generator strobes and the loop mask that gates them
  input logic             [`RP_CHN-1:0] gen_vld_i,
  input rp_pkg::loop_mask_t             loop_i,
  input rp_pkg::dac_raw_t [`RP_CHN-1:0] dac_dat_i,
  input logic             [`RP_CHN-1:0] osc_vld_i,
  input logic         [`RP_PDM_CHN-1:0] pdm_i,
  input logic                           reg_re_i,
  input logic                           reg_rvalid_i
);

  // failed assertion count
  int unsigned assert_errs = 0;

  // outputs quiet in reset, sampled mid-cycle
  a_rst_quiet: assert property (@(negedge adc_clk) top_rst |-> (osc_vld_i == '0) && (pdm_i == '0))
    else begin
      $error("osc_vld_o or pdm_o active while top_rst is high");
      assert_errs++;
    end

  // no valid sample or looped channel, no new code
  for (genvar c = 0; c < `RP_CHN; c++) begin : g_dac_hold
    a_dac_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
      (!gen_vld_i[c] || loop_i[c]) |=> $stable(dac_dat_i[c]))
      else begin
        $error("dac_dat_o[%0d] changed without a DAC update", c);
        assert_errs++;
      end
  end

  // read return exactly one edge after the strobe
  a_rd_valid: assert property (@(posedge adc_clk) disable iff (top_rst)
    reg_re_i |=> reg_rvalid_i)
    else begin
      $error("reg_rvalid_o missing after reg_re_i");
      assert_errs++;
    end

  a_rd_single: assert property (@(posedge adc_clk) disable iff (top_rst)
    !reg_re_i |=> !reg_rvalid_i)
    else begin
      $error("reg_rvalid_o without a read strobe");
      assert_errs++;
    end

endmodule

bind analog_top analog_checker u_analog_checker (
  .adc_clk      (adc_clk),
  .top_rst      (top_rst),
  .gen_vld_i    (gen_vld_i),
  .loop_i       (loop),
  .dac_dat_i    (dac_dat_o),
  .osc_vld_i    (osc_vld_o),
  .pdm_i        (pdm_o),
  .reg_re_i     (reg_re_i),
  .reg_rvalid_i (reg_rvalid_o)
);

// ==== tests/tb_analog_top.sv ====
`timescale 1ns/1ps
`include "rp_params.svh"

module tb_analog_top;

  localparam int CLK_PERIOD = 20;
  localparam int PDM_RANGE = 255;
  localparam int PDM_ROUNDS = 6;
  // reset, ADC, DAC, loop, register and PDM phases
  localparam int TEST_CYCLES = 3 + 200 + 200 + 4 * 122 + 100 * 4 + PDM_ROUNDS * 261;
  localparam int MARGIN_CYCLES = 200;

  logic                               adc_clk;
  logic                               top_rst;
  rp_pkg::adc_raw_t [`RP_CHN-1:0]     adc_dat_i;
  rp_pkg::gen_dat_t [`RP_CHN-1:0]     gen_dat_i;
  logic             [`RP_CHN-1:0]     gen_vld_i;
  logic                               reg_we_i;
  logic                               reg_re_i;
  rp_pkg::reg_addr_t                  reg_addr_i;
  rp_pkg::reg_data_t                  reg_wdata_i;
  rp_pkg::reg_data_t                  reg_rdata_o;
  logic                               reg_rvalid_o;
  rp_pkg::osc_dat_t [`RP_CHN-1:0]     osc_dat_o;
  logic             [`RP_CHN-1:0]     osc_vld_o;
  rp_pkg::dac_raw_t [`RP_CHN-1:0]     dac_dat_o;
  logic             [`RP_PDM_CHN-1:0] pdm_o;

  // LFSR state and generator strobe enable
  logic [15:0] lfsr;
  logic        gen_en;

  //////////////////////////////////////////////////
  // reference model state, starts at reset values
  //////////////////////////////////////////////////
  rp_pkg::adc_raw_t       m_adc_raw [`RP_CHN] = '{default: '0};
  rp_pkg::osc_dat_t       m_osc_dat [`RP_CHN] = '{default: '0};
  logic [`RP_CHN-1:0]     m_osc_vld = '0;
  logic                   m_fill = 1'b0;
  // mid-scale out of reset
  rp_pkg::dac_raw_t       m_dac [`RP_CHN] = '{default: 14'h1FFF};
  rp_pkg::loop_mask_t     m_loop = '0;
  rp_pkg::pdm_lvl_t       m_lvl [`RP_PDM_CHN] = '{default: '0};
  int                     m_acc [`RP_PDM_CHN] = '{default: 0};
  logic [`RP_PDM_CHN-1:0] m_pdm = '0;
  rp_pkg::reg_data_t      m_rdata = '0;
  logic                   m_rvalid = 1'b0;

  analog_top u_analog_top (.*);

  initial begin
    adc_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // zero for unmapped addresses
  function automatic rp_pkg::reg_data_t model_read(input int addr);
    rp_pkg::reg_data_t val;
    val = '0;
    if (addr == `RP_ADDR_LOOP) begin
      val[1:0] = m_loop;
    end else if (addr >= `RP_ADDR_PDM0 && addr < `RP_ADDR_PDM0 + `RP_PDM_CHN) begin
      val = m_lvl[addr - `RP_ADDR_PDM0];
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // model update for one clock edge
  //////////////////////////////////////////////////
  task automatic model_edge();
    int sum;
    // read sees the registers before any write at this edge
    m_rvalid = reg_re_i;
    if (reg_re_i) begin
      m_rdata = model_read(reg_addr_i);
    end
    for (int c = 0; c < `RP_CHN; c++) begin
      if (m_loop[c]) begin
        // generator looped back, DAC holds
        m_osc_dat[c] = {gen_dat_i[c], 2'b00};
        m_osc_vld[c] = gen_vld_i[c];
      end else begin
        // sign kept, other bits flipped
        m_osc_dat[c] = m_adc_raw[c] ^ 16'h7FFF;
        m_osc_vld[c] = m_fill;
        if (gen_vld_i[c]) begin
          m_dac[c] = gen_dat_i[c] ^ 14'h1FFF;
        end
      end
      m_adc_raw[c] = adc_dat_i[c];
    end
    m_fill = 1'b1;
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      sum = m_acc[n] + m_lvl[n];
      m_pdm[n] = (sum >= PDM_RANGE);
      m_acc[n] = (sum >= PDM_RANGE) ? sum - PDM_RANGE : sum;
    end
    if (reg_we_i) begin
      if (reg_addr_i == `RP_ADDR_LOOP) begin
        m_loop = reg_wdata_i[1:0];
      end else if (reg_addr_i >= `RP_ADDR_PDM0 && reg_addr_i < `RP_ADDR_PDM0 + `RP_PDM_CHN) begin
        m_lvl[reg_addr_i - `RP_ADDR_PDM0] = reg_wdata_i;
      end
    end
  endtask

  task automatic check_outputs();
    for (int c = 0; c < `RP_CHN; c++) begin
      compare_value($sformatf("osc_dat_o[%0d]", c), osc_dat_o[c], m_osc_dat[c]);
      compare_value($sformatf("osc_vld_o[%0d]", c), osc_vld_o[c], m_osc_vld[c]);
      compare_value($sformatf("dac_dat_o[%0d]", c), dac_dat_o[c], m_dac[c]);
    end
    compare_value("pdm_o", pdm_o, m_pdm);
    compare_value("reg_rvalid_o", reg_rvalid_o, m_rvalid);
    compare_value("reg_rdata_o", reg_rdata_o, m_rdata);
  endtask

  // model the edge, drive the next inputs, check at the falling edge
  task automatic tick(input logic we, input logic re, input int addr, input int wdata);
    rp_pkg::adc_raw_t [`RP_CHN-1:0] adc_nxt;
    rp_pkg::gen_dat_t [`RP_CHN-1:0] gen_nxt;
    logic [`RP_CHN-1:0]             vld_nxt;
    @(posedge adc_clk);
    model_edge();
    for (int c = 0; c < `RP_CHN; c++) begin
      adc_nxt[c] = rp_pkg::adc_raw_t'(rand_bits(16));
      gen_nxt[c] = rp_pkg::gen_dat_t'(rand_bits(14));
      vld_nxt[c] = (rand_bits(1) != 0) && gen_en;
    end
    adc_dat_i   <= adc_nxt;
    gen_dat_i   <= gen_nxt;
    gen_vld_i   <= vld_nxt;
    reg_we_i    <= we;
    reg_re_i    <= re;
    reg_addr_i  <= rp_pkg::reg_addr_t'(addr);
    reg_wdata_i <= rp_pkg::reg_data_t'(wdata);
    @(negedge adc_clk);
    check_outputs();
  endtask

  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    $display("watchdog expired, test sequence did not finish within %0d cycles", TEST_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    rp_pkg::pdm_lvl_t lvl [`RP_PDM_CHN];
    int ones [`RP_PDM_CHN];
    int addr;
    lfsr = 16'd40;
    gen_en = 1'b0;
    top_rst = 1'b1;
    adc_dat_i = '0;
    gen_dat_i = '0;
    gen_vld_i = '0;
    reg_we_i = 1'b0;
    reg_re_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    // outputs held at reset values, release on the third edge
    for (int i = 0; i < 3; i++) begin
      @(posedge adc_clk);
      if (i == 2) begin
        top_rst <= 1'b0;
      end
      @(negedge adc_clk);
      check_outputs();
    end
    // ADC path with generator idle
    repeat (200) tick(0, 0, 0, 0);
    // generator to DAC
    gen_en = 1'b1;
    repeat (200) tick(0, 0, 0, 0);
    // loop channel 0, then 1, then both, then release
    for (int m = 1; m <= 4; m++) begin
      tick(1, 0, `RP_ADDR_LOOP, m % 4);
      repeat (121) tick(0, 0, 0, 0);
    end
    // whole 3-bit address space, unmapped included
    for (int i = 0; i < 100; i++) begin
      addr = rand_bits(3);
      tick(1, 0, addr, rand_bits(8));
      tick(0, 1, addr, 0);
      tick(0, 1, rand_bits(3), 0);
      tick(0, 0, 0, 0);
    end
    //////////////////////////////////////////////////
    // PDM density over one full range window
    //////////////////////////////////////////////////
    for (int r = 0; r < PDM_ROUNDS; r++) begin
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        lvl[n] = rp_pkg::pdm_lvl_t'(rand_bits(8));
        ones[n] = 0;
      end
      // both ends of the range once
      if (r == 0) begin
        lvl[0] = 8'd0;
        lvl[1] = 8'd255;
      end
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        tick(1, 0, `RP_ADDR_PDM0 + n, lvl[n]);
      end
      // write lands next edge, new level in use one edge later
      repeat (2) tick(0, 0, 0, 0);
      repeat (PDM_RANGE) begin
        tick(0, 0, 0, 0);
        for (int n = 0; n < `RP_PDM_CHN; n++) begin
          ones[n] += pdm_o[n];
        end
      end
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        compare_value($sformatf("pdm_o[%0d] ones", n), ones[n], lvl[n]);
      end
    end
    if (u_analog_top.u_analog_checker.assert_errs == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound checker",
               u_analog_top.u_analog_checker.assert_errs);
      $display("TESTBENCH FAILED");
      $fatal(1, "assertion failures during the run");
    end
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rp_pkg.sv
hdl/adc_frontend.sv
hdl/dac_backend.sv
hdl/loop_router.sv
hdl/pdm_modulator.sv
hdl/analog_regs.sv
hdl/analog_top.sv
tests/analog_checker.sv
tests/tb_analog_top.sv

// ==== Bender.yml ====
package:
  name: analog_top

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/rp_pkg.sv
      - hdl/adc_frontend.sv
      - hdl/dac_backend.sv
      - hdl/loop_router.sv
      - hdl/pdm_modulator.sv
      - hdl/analog_regs.sv
      - hdl/analog_top.sv
  - target: test
    files:
      - tests/analog_checker.sv
      - tests/tb_analog_top.sv
